// ==== fpga_top_som_consts.svh ====
`ifndef FPGA_TOP_SOM_CONSTS_SVH
`define FPGA_TOP_SOM_CONSTS_SVH

// **************************************************
// Bus widths
// **************************************************
`define WB_DATA_W      32
`define WB_SEL_W       4

// Region field of the byte address
`define REGION_MSB     31
`define REGION_LSB     28
`define CSR_REGION     4'h0   // Pipeline control/status
`define PIX_REGION     4'h1   // Pixel-domain slave, tie-off for now
`define USB_REGION     4'h2   // USB config space over LMMI

// **************************************************
// CSR word offsets, byte address bits 5:2
// **************************************************
`define CSR_CTRL       4'd0
`define CSR_NUM_COLS   4'd1
`define CSR_NUM_ROWS   4'd2
`define CSR_NUM_FRAMES 4'd3
`define CSR_GAINS      4'd4
`define CSR_STATUS     4'd5   // Read only
`define CSR_AVG0       4'd6   // Read only, up to AVG3
`define CSR_AVG1       4'd7
`define CSR_AVG2       4'd8
`define CSR_AVG3       4'd9

// Frame geometry, full HD unless the fast variant is picked
`define NUM_COLS_DEF   1920
`define NUM_ROWS_DEF   1080
`define NUM_COLS_FAST  40
`define NUM_ROWS_FAST  30
`define COL_W          12
`define ROW_W          11
`define CTRL_W         4      // rx_en, tx_en, pattern en, pattern type

`define GAIN_W         8
`define NUM_CHAN       4
`define PIX_STUB_DATA  32'hFEEDF00D
`define LMMI_OFFSET_W  15

`endif

// ==== fpga_top_som_pkg.sv ====
`default_nettype none

`include "fpga_top_som_consts.svh"

package fpga_top_som_pkg;

  // **************************************************
  // Bus payloads
  // **************************************************
  typedef logic [`WB_DATA_W-1:0] wb_data_t;   // One bus word
  typedef logic [`WB_SEL_W-1:0]  wb_sel_t;    // One bit per byte lane

  // Image pipeline per-channel values
  typedef logic [`GAIN_W-1:0]    gain_t;
  typedef logic [31:0]           avg_t;       // Accumulated channel average

  // Word offset into the USB core config space
  typedef logic [`LMMI_OFFSET_W-1:0] lmmi_offset_t;

endpackage

`default_nettype wire

// ==== wb_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpga_top_som_consts.svh"

module wb_addr_decode (
  input  wire                        wb_clk_i,
  input  wire                        reset_i,
  input  wire fpga_top_som_pkg::wb_data_t adr_i,   // Byte address
  input  wire                        cyc_i,
  input  wire                        stb_i,
  input  wire fpga_top_som_pkg::wb_data_t csr_dat_i,
  input  wire                        csr_ack_i,
  input  wire fpga_top_som_pkg::wb_data_t usb_dat_i,
  input  wire                        usb_ack_i,
  output logic                       csr_stb_o,
  output logic                       usb_stb_o,
  output fpga_top_som_pkg::wb_data_t dat_o,
  output logic                       ack_o,
  output logic                       err_o
);

  logic [`REGION_MSB-`REGION_LSB:0] region;
  logic req;
  logic csr_hit, pix_hit, usb_hit;
  logic pix_ack;
  logic err_q;

  assign region  = adr_i[`REGION_MSB:`REGION_LSB];
  assign req     = cyc_i & stb_i;
  assign csr_hit = (region == `CSR_REGION);
  assign pix_hit = (region == `PIX_REGION);
  assign usb_hit = (region == `USB_REGION);

  // Qualified strobes towards the real slaves
  assign csr_stb_o = req & csr_hit;
  assign usb_stb_o = req & usb_hit;

  // Pixel tie-off answers in the same cycle
  assign pix_ack = req & pix_hit;

  // **************************************************
  // Unmapped space
  // **************************************************
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & ~csr_hit & ~pix_hit & ~usb_hit & ~err_q;   // One pulse per strobe
    end
  end

  assign err_o = err_q;
  assign ack_o = csr_ack_i | usb_ack_i | pix_ack;

  // Return path follows the held address
  always_comb begin
    case (region)
      `CSR_REGION: dat_o = csr_dat_i;
      `PIX_REGION: dat_o = `PIX_STUB_DATA;
      `USB_REGION: dat_o = usb_dat_i;
      default:     dat_o = '0;
    endcase
  end

  // At most one slave sees a strobe
  a_one_slave: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    !(csr_stb_o && usb_stb_o));

  // Error and ack never overlap on the master port
  a_err_no_ack: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    err_o |-> !ack_o);

endmodule

`default_nettype wire

// ==== wb_csr_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpga_top_som_consts.svh"

module wb_csr_bank #(
  parameter bit FAST_SIM = 1'b0   // Smaller frame for quick sim runs
) (
  input  wire                        wb_clk_i,
  input  wire                        reset_i,
  input  wire                        stb_i,       // Already qualified by cyc and region
  input  wire                        we_i,
  input  wire [3:0]                  word_i,
  input  wire fpga_top_som_pkg::wb_data_t dat_i,
  input  wire fpga_top_som_pkg::wb_sel_t  sel_i,
  input  wire                        pll_locked_i,
  input  wire                        buffer_full_err_i,
  input  wire fpga_top_som_pkg::avg_t [`NUM_CHAN-1:0] avg_chan_i,
  output fpga_top_som_pkg::wb_data_t dat_o,
  output logic                       ack_o,
  output logic                       rx_en_o,
  output logic                       tx_en_o,
  output logic                       test_pattern_en_o,
  output logic                       test_pattern_type_o,
  output logic [`COL_W-1:0]          num_cols_o,
  output logic [`ROW_W-1:0]          num_rows_o,
  output fpga_top_som_pkg::wb_data_t num_frames_o,
  output fpga_top_som_pkg::gain_t [`NUM_CHAN-1:0] gain_chan_o
);

  localparam logic [`COL_W-1:0] COLS_RST = FAST_SIM ? `NUM_COLS_FAST : `NUM_COLS_DEF;
  localparam logic [`ROW_W-1:0] ROWS_RST = FAST_SIM ? `NUM_ROWS_FAST : `NUM_ROWS_DEF;

  logic [`CTRL_W-1:0]         ctrl_q;
  logic [`COL_W-1:0]          cols_q;
  logic [`ROW_W-1:0]          rows_q;
  fpga_top_som_pkg::wb_data_t frames_q;
  fpga_top_som_pkg::gain_t [`NUM_CHAN-1:0] gains_q;   // Channel 0 in low byte
  logic                       ack_q;
  logic                       wr_en;
  fpga_top_som_pkg::wb_data_t merged;

  // Replace only the enabled byte lanes
  function automatic fpga_top_som_pkg::wb_data_t merge_bytes(
    input fpga_top_som_pkg::wb_data_t old_val,
    input fpga_top_som_pkg::wb_data_t new_val,
    input fpga_top_som_pkg::wb_sel_t  sel
  );
    fpga_top_som_pkg::wb_data_t res;
    res = old_val;
    for (int b = 0; b < `WB_SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // **************************************************
  // Read mux
  // **************************************************
  always_comb begin
    case (word_i)
      `CSR_CTRL:       dat_o = fpga_top_som_pkg::wb_data_t'(ctrl_q);
      `CSR_NUM_COLS:   dat_o = fpga_top_som_pkg::wb_data_t'(cols_q);
      `CSR_NUM_ROWS:   dat_o = fpga_top_som_pkg::wb_data_t'(rows_q);
      `CSR_NUM_FRAMES: dat_o = frames_q;
      `CSR_GAINS:      dat_o = fpga_top_som_pkg::wb_data_t'(gains_q);
      `CSR_STATUS:     dat_o = {30'd0, buffer_full_err_i, pll_locked_i};
      `CSR_AVG0:       dat_o = avg_chan_i[0];
      `CSR_AVG1:       dat_o = avg_chan_i[1];
      `CSR_AVG2:       dat_o = avg_chan_i[2];
      `CSR_AVG3:       dat_o = avg_chan_i[3];
      default:         dat_o = '0;   // Holes read as zero
    endcase
  end

  // Current value with new bytes laid over it
  assign merged = merge_bytes(dat_o, dat_i, sel_i);
  assign wr_en  = stb_i & we_i & ~ack_q;   // First cycle of the strobe only

  // **************************************************
  // Registers
  // **************************************************
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q    <= 1'b0;
      ctrl_q   <= '0;
      cols_q   <= COLS_RST;
      rows_q   <= ROWS_RST;
      frames_q <= '0;
      gains_q  <= '0;
    end else begin
      ack_q <= stb_i & ~ack_q;
      if (wr_en) begin
        case (word_i)
          `CSR_CTRL:       ctrl_q   <= merged[`CTRL_W-1:0];
          `CSR_NUM_COLS:   cols_q   <= merged[`COL_W-1:0];
          `CSR_NUM_ROWS:   rows_q   <= merged[`ROW_W-1:0];
          `CSR_NUM_FRAMES: frames_q <= merged;
          `CSR_GAINS:      gains_q  <= merged[`NUM_CHAN*`GAIN_W-1:0];
          default:         ;   // Read-only or hole, ack anyway
        endcase
      end
    end
  end

  assign ack_o               = ack_q;
  assign rx_en_o             = ctrl_q[0];
  assign tx_en_o             = ctrl_q[1];
  assign test_pattern_en_o   = ctrl_q[2];
  assign test_pattern_type_o = ctrl_q[3];
  assign num_cols_o          = cols_q;
  assign num_rows_o          = rows_q;
  assign num_frames_o        = frames_q;
  assign gain_chan_o         = gains_q;

  // Master drops the strobe after ack, so no back-to-back acks
  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    ack_o |=> !ack_o);

endmodule

`default_nettype wire

// ==== wb_lmmi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpga_top_som_consts.svh"

module wb_lmmi_bridge (
  input  wire                        wb_clk_i,
  input  wire                        reset_i,
  input  wire                        stb_i,
  input  wire                        we_i,
  input  wire fpga_top_som_pkg::wb_data_t adr_i,   // Byte address
  input  wire fpga_top_som_pkg::wb_data_t dat_i,
  input  wire                        lmmi_ready_i,
  input  wire                        lmmi_rdata_valid_i,
  input  wire fpga_top_som_pkg::wb_data_t lmmi_rdata_i,
  output fpga_top_som_pkg::wb_data_t dat_o,
  output logic                       ack_o,
  output logic                       lmmi_request_o,
  output logic                       lmmi_wr_rdn_o,
  output fpga_top_som_pkg::lmmi_offset_t lmmi_offset_o,
  output fpga_top_som_pkg::wb_data_t lmmi_wdata_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RDY,    // Request goes out once the core is ready
    WAIT_DATA,   // Reads only
    DONE         // Ack, then wait for strobe low
  } state_t;

  state_t                         state_q, state_d;
  logic                           ack_q;
  logic                           wr_q;
  fpga_top_som_pkg::lmmi_offset_t offset_q;
  fpga_top_som_pkg::wb_data_t     wdata_q;
  fpga_top_som_pkg::wb_data_t     rdata_q;

  // **************************************************
  // FSM
  // **************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (stb_i) state_d = WAIT_RDY;
      WAIT_RDY:  if (lmmi_ready_i) state_d = wr_q ? DONE : WAIT_DATA;   // Write done on pulse
      WAIT_DATA: if (lmmi_rdata_valid_i) state_d = DONE;
      DONE:      if (!stb_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= (state_d == DONE) && (state_q != DONE);   // Entry into DONE only
    end
  end

  // Request fields latched at the start of the cycle
  always_ff @(posedge wb_clk_i) begin
    if (state_q == IDLE && stb_i) begin
      wr_q     <= we_i;
      offset_q <= adr_i[`LMMI_OFFSET_W+1:2];
      wdata_q  <= dat_i;
    end
    if (state_q == WAIT_DATA && lmmi_rdata_valid_i) begin
      rdata_q <= lmmi_rdata_i;   // Held until ack
    end
  end

  assign lmmi_request_o = (state_q == WAIT_RDY) & lmmi_ready_i;   // Single-cycle pulse
  assign lmmi_wr_rdn_o  = wr_q;
  assign lmmi_offset_o  = offset_q;
  assign lmmi_wdata_o   = wdata_q;
  assign dat_o          = rdata_q;
  assign ack_o          = ack_q;

  a_req_ready: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    lmmi_request_o |-> lmmi_ready_i);

  a_req_state: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    lmmi_request_o |-> (state_q == WAIT_RDY));

endmodule

`default_nettype wire

// ==== fpga_top_som.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpga_top_som_consts.svh"

module fpga_top_som #(
  parameter bit FAST_SIM = 1'b0
) (
  input  wire                        wb_clk_i,
  input  wire                        reset_i,
  // Wishbone master port from the SoC
  input  wire [29:0]                 wb_adr_i,   // Word address
  input  wire fpga_top_som_pkg::wb_data_t wb_dat_i,
  input  wire fpga_top_som_pkg::wb_sel_t  wb_sel_i,
  input  wire                        wb_we_i,
  input  wire                        wb_cyc_i,
  input  wire                        wb_stb_i,
  output fpga_top_som_pkg::wb_data_t wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       wb_err_o,
  // Image pipeline side
  input  wire                        pll_locked_i,
  input  wire                        buffer_full_err_i,
  input  wire fpga_top_som_pkg::avg_t [`NUM_CHAN-1:0] avg_chan_i,
  output logic                       rx_en_o,
  output logic                       tx_en_o,
  output logic                       test_pattern_en_o,
  output logic                       test_pattern_type_o,
  output logic [`COL_W-1:0]          num_cols_o,
  output logic [`ROW_W-1:0]          num_rows_o,
  output fpga_top_som_pkg::wb_data_t num_frames_o,
  output fpga_top_som_pkg::gain_t [`NUM_CHAN-1:0] gain_chan_o,
  // USB core config port
  input  wire                        lmmi_ready_i,
  input  wire                        lmmi_rdata_valid_i,
  input  wire fpga_top_som_pkg::wb_data_t lmmi_rdata_i,
  output logic                       lmmi_request_o,
  output logic                       lmmi_wr_rdn_o,
  output fpga_top_som_pkg::lmmi_offset_t lmmi_offset_o,
  output fpga_top_som_pkg::wb_data_t lmmi_wdata_o
);

  fpga_top_som_pkg::wb_data_t byte_adr;
  fpga_top_som_pkg::wb_data_t csr_dat, usb_dat;
  logic csr_stb, csr_ack;
  logic usb_stb, usb_ack;

  // Bus is 32-bit aligned
  assign byte_adr = {wb_adr_i, 2'b00};

  // **************************************************
  // Region decode and return mux
  // **************************************************
  wb_addr_decode i_wb_addr_decode (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i ),
    .adr_i    (byte_adr),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .csr_dat_i(csr_dat ),
    .csr_ack_i(csr_ack ),
    .usb_dat_i(usb_dat ),
    .usb_ack_i(usb_ack ),
    .csr_stb_o(csr_stb ),
    .usb_stb_o(usb_stb ),
    .dat_o    (wb_dat_o),
    .ack_o    (wb_ack_o),
    .err_o    (wb_err_o)
  );

  wb_csr_bank #(
    .FAST_SIM(FAST_SIM)
  ) i_wb_csr_bank (
    .wb_clk_i           (wb_clk_i           ),
    .reset_i            (reset_i            ),
    .stb_i              (csr_stb            ),
    .we_i               (wb_we_i            ),
    .word_i             (byte_adr[5:2]      ),   // Word offset in the bank
    .dat_i              (wb_dat_i           ),
    .sel_i              (wb_sel_i           ),
    .pll_locked_i       (pll_locked_i       ),
    .buffer_full_err_i  (buffer_full_err_i  ),
    .avg_chan_i         (avg_chan_i         ),
    .dat_o              (csr_dat            ),
    .ack_o              (csr_ack            ),
    .rx_en_o            (rx_en_o            ),
    .tx_en_o            (tx_en_o            ),
    .test_pattern_en_o  (test_pattern_en_o  ),
    .test_pattern_type_o(test_pattern_type_o),
    .num_cols_o         (num_cols_o         ),
    .num_rows_o         (num_rows_o         ),
    .num_frames_o       (num_frames_o       ),
    .gain_chan_o        (gain_chan_o        )
  );

  // USB config space through LMMI
  wb_lmmi_bridge i_wb_lmmi_bridge (
    .wb_clk_i          (wb_clk_i          ),
    .reset_i           (reset_i           ),
    .stb_i             (usb_stb           ),
    .we_i              (wb_we_i           ),
    .adr_i             (byte_adr          ),
    .dat_i             (wb_dat_i          ),
    .lmmi_ready_i      (lmmi_ready_i      ),
    .lmmi_rdata_valid_i(lmmi_rdata_valid_i),
    .lmmi_rdata_i      (lmmi_rdata_i      ),
    .dat_o             (usb_dat           ),
    .ack_o             (usb_ack           ),
    .lmmi_request_o    (lmmi_request_o    ),
    .lmmi_wr_rdn_o     (lmmi_wr_rdn_o     ),
    .lmmi_offset_o     (lmmi_offset_o     ),
    .lmmi_wdata_o      (lmmi_wdata_o      )
  );

endmodule

`default_nettype wire

// ==== tb_fpga_top_som.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpga_top_som_consts.svh"

module tb_fpga_top_som;

  localparam int ACK_TIMEOUT = 100;   // Cycles allowed per bus access

  logic wb_clk_i = 1'b0;
  logic reset_i;

  // Wishbone master side, played by the testbench
  logic [29:0]                wb_adr_i;
  fpga_top_som_pkg::wb_data_t wb_dat_i;
  fpga_top_som_pkg::wb_sel_t  wb_sel_i;
  logic                       wb_we_i;
  logic                       wb_cyc_i;
  logic                       wb_stb_i;
  fpga_top_som_pkg::wb_data_t wb_dat_o;
  logic                       wb_ack_o;
  logic                       wb_err_o;

  // Image pipeline side
  logic                                   pll_locked_i;
  logic                                   buffer_full_err_i;
  fpga_top_som_pkg::avg_t [`NUM_CHAN-1:0] avg_chan_i;
  logic                                   rx_en_o;
  logic                                   tx_en_o;
  logic                                   test_pattern_en_o;
  logic                                   test_pattern_type_o;
  logic [`COL_W-1:0]                      num_cols_o;
  logic [`ROW_W-1:0]                      num_rows_o;
  fpga_top_som_pkg::wb_data_t             num_frames_o;
  fpga_top_som_pkg::gain_t [`NUM_CHAN-1:0] gain_chan_o;

  // USB core config port
  logic                           lmmi_ready_i;
  logic                           lmmi_rdata_valid_i;
  fpga_top_som_pkg::wb_data_t     lmmi_rdata_i;
  logic                           lmmi_request_o;
  logic                           lmmi_wr_rdn_o;
  fpga_top_som_pkg::lmmi_offset_t lmmi_offset_o;
  fpga_top_som_pkg::wb_data_t     lmmi_wdata_o;

  int          chk_cnt = 0;
  int          err_cnt = 0;
  int          req_cnt = 0;          // Request pulses seen by the responder
  logic [14:0] wr_off_log [$];       // Writes received over LMMI
  logic [31:0] wr_dat_log [$];
  logic [31:0] csr_model [0:4];      // Expected RW register contents

  fpga_top_som i_fpga_top_som (.*);

  always #5 wb_clk_i = ~wb_clk_i;

  // **************************************************
  // Protocol assertions
  // **************************************************
  a_req_ready: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    lmmi_request_o |-> lmmi_ready_i)
    else begin
      $display("%0t: LMMI request raised while the core was not ready", $time);
      err_cnt++;
    end

  a_req_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    lmmi_request_o |=> !lmmi_request_o)
    else begin
      $display("%0t: LMMI request held longer than one cycle", $time);
      err_cnt++;
    end

  // USB write acks in the cycle after its request pulse
  a_usb_wr_ack: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (lmmi_request_o && lmmi_wr_rdn_o) |=> wb_ack_o)
    else begin
      $display("%0t: no ack in the cycle after an LMMI write request", $time);
      err_cnt++;
    end

  // USB read acks in the cycle after the data pulse
  a_usb_rd_ack: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    lmmi_rdata_valid_i |=> wb_ack_o)
    else begin
      $display("%0t: no ack in the cycle after LMMI read data was valid", $time);
      err_cnt++;
    end

  a_err_excl: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    wb_err_o |-> !wb_ack_o)
    else begin
      $display("%0t: ack and err high in the same cycle", $time);
      err_cnt++;
    end

  a_err_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    wb_err_o |=> !wb_err_o)
    else begin
      $display("%0t: err held longer than one cycle", $time);
      err_cnt++;
    end

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    chk_cnt++;
    assert (act === exp) else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic test_done(input string name, input int err_before);
    $display("test %s finished with %0d errors", name, err_cnt - err_before);
  endtask

  // One classic cycle, resp 1 for ack, 2 for err, 0 for nothing
  task automatic wb_cycle(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
                          input logic [3:0] sel, output logic [31:0] rdat,
                          output int resp, output int lat);
    rdat = '0;
    resp = 0;
    lat  = 0;
    @(posedge wb_clk_i);
    #1;
    wb_adr_i = adr[31:2];   // Word address on the bus
    wb_we_i  = we;
    wb_dat_i = wdat;
    wb_sel_i = sel;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    while (resp == 0 && lat <= ACK_TIMEOUT) begin
      @(negedge wb_clk_i);   // Mid-cycle, outputs settled
      if (wb_ack_o) begin
        resp = 1;
        rdat = wb_dat_o;
      end else if (wb_err_o) begin
        resp = 2;
      end else begin
        lat++;
      end
    end
    if (resp == 0) begin
      $display("%0t: no ack or err for address %h within %0d cycles", $time, adr, ACK_TIMEOUT);
      err_cnt++;
    end
    @(posedge wb_clk_i);
    #1;
    wb_cyc_i = 1'b0;   // Strobe low for at least a cycle
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat,
                          input logic [3:0] sel, output int resp, output int lat);
    logic [31:0] unused_rd;
    wb_cycle(adr, 1'b1, wdat, sel, unused_rd, resp, lat);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat,
                         output int resp, output int lat);
    wb_cycle(adr, 1'b0, '0, 4'hF, rdat, resp, lat);
  endtask

  // CSR byte address, upper bits inside the region randomized
  function automatic logic [31:0] csr_addr(input logic [3:0] off);
    return {`CSR_REGION, 22'($urandom), off, 2'b00};
  endfunction

  function automatic logic [31:0] reg_mask(input logic [3:0] off);
    case (off)
      `CSR_CTRL:     return (32'd1 << `CTRL_W) - 1;
      `CSR_NUM_COLS: return (32'd1 << `COL_W) - 1;
      `CSR_NUM_ROWS: return (32'd1 << `ROW_W) - 1;
      default:       return 32'hFFFF_FFFF;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic csr_write(input logic [3:0] off, input logic [31:0] wdat, input logic [3:0] sel);
    int          resp;
    int          lat;
    logic [31:0] m;
    wb_write(csr_addr(off), wdat, sel, resp, lat);
    check_eq("csr write response", resp, 1);
    check_eq("csr ack latency", lat, 1);
    m = lane_mask(sel);
    if (off <= `CSR_GAINS) begin   // Read-only and holes keep nothing
      csr_model[off] = ((csr_model[off] & ~m) | (wdat & m)) & reg_mask(off);
    end
  endtask

  task automatic csr_expect(input logic [3:0] off, input logic [31:0] exp);
    logic [31:0] rd;
    int          resp;
    int          lat;
    wb_read(csr_addr(off), rd, resp, lat);
    check_eq("csr read response", resp, 1);
    check_eq("csr ack latency", lat, 1);
    check_eq($sformatf("wb_dat_o csr word %0d", off), rd, exp);
  endtask

  task automatic outputs_vs_model();
    logic [31:0] ctrl;
    ctrl = csr_model[`CSR_CTRL];
    check_eq("rx_en_o", {31'd0, rx_en_o}, {31'd0, ctrl[0]});
    check_eq("tx_en_o", {31'd0, tx_en_o}, {31'd0, ctrl[1]});
    check_eq("test_pattern_en_o", {31'd0, test_pattern_en_o}, {31'd0, ctrl[2]});
    check_eq("test_pattern_type_o", {31'd0, test_pattern_type_o}, {31'd0, ctrl[3]});
    check_eq("num_cols_o", 32'(num_cols_o), csr_model[`CSR_NUM_COLS]);
    check_eq("num_rows_o", 32'(num_rows_o), csr_model[`CSR_NUM_ROWS]);
    check_eq("num_frames_o", num_frames_o, csr_model[`CSR_NUM_FRAMES]);
    check_eq("gain_chan_o", 32'(gain_chan_o), csr_model[`CSR_GAINS]);   // Channel 0 low byte
  endtask

  // **************************************************
  // Tests
  // **************************************************
  task automatic reset_state();
    int e0;
    e0 = err_cnt;
    check_eq("lmmi_request_o", {31'd0, lmmi_request_o}, 32'd0);
    check_eq("num_cols_o", 32'(num_cols_o), `NUM_COLS_DEF);
    check_eq("num_rows_o", 32'(num_rows_o), `NUM_ROWS_DEF);
    outputs_vs_model();   // Model still holds reset values
    csr_expect(`CSR_CTRL, 32'd0);
    csr_expect(`CSR_GAINS, 32'd0);
    csr_expect(`CSR_NUM_FRAMES, 32'd0);
    test_done("reset_state", e0);
  endtask

  task automatic csr_readback();
    int         e0;
    logic [3:0] off;
    e0 = err_cnt;
    for (int i = 0; i < 40; i++) begin
      off = 4'($urandom % 5);
      csr_write(off, $urandom, 4'($urandom));   // Any sel, zero included
      csr_expect(off, csr_model[off]);
      outputs_vs_model();
    end
    test_done("csr_readback", e0);
  endtask

  task automatic status_regs();
    int e0;
    e0 = err_cnt;
    for (int r = 0; r < 4; r++) begin
      @(posedge wb_clk_i);
      #1;
      for (int c = 0; c < `NUM_CHAN; c++) avg_chan_i[c] = $urandom;
      pll_locked_i      = 1'($urandom);
      buffer_full_err_i = 1'($urandom);
      for (int c = 0; c < `NUM_CHAN; c++) csr_expect(4'(`CSR_AVG0 + c), avg_chan_i[c]);
      csr_expect(`CSR_STATUS, {30'd0, buffer_full_err_i, pll_locked_i});
      // Writes to read-only words and holes are dropped
      for (int o = `CSR_STATUS; o <= `CSR_AVG3; o++) csr_write(4'(o), $urandom, 4'hF);
      csr_write(4'(10 + r), $urandom, 4'hF);
      for (int c = 0; c < `NUM_CHAN; c++) csr_expect(4'(`CSR_AVG0 + c), avg_chan_i[c]);
      csr_expect(`CSR_STATUS, {30'd0, buffer_full_err_i, pll_locked_i});
      csr_expect(4'(10 + r), 32'd0);
    end
    outputs_vs_model();
    test_done("status_regs", e0);
  endtask

  task automatic pixel_stub();
    int          e0;
    int          resp;
    int          lat;
    logic [31:0] adr;
    logic [31:0] rd;
    e0 = err_cnt;
    for (int i = 0; i < 6; i++) begin
      adr = {`PIX_REGION, 26'($urandom), 2'b00};
      wb_read(adr, rd, resp, lat);
      check_eq("pixel read response", resp, 1);
      check_eq("pixel ack latency", lat, 0);   // Same cycle as the strobe
      check_eq("wb_dat_o pixel", rd, `PIX_STUB_DATA);
      wb_write(adr, $urandom, 4'hF, resp, lat);
      check_eq("pixel write response", resp, 1);
      check_eq("pixel ack latency", lat, 0);
    end
    test_done("pixel_stub", e0);
  endtask

  task automatic usb_bridge();
    int          e0;
    int          resp;
    int          lat;
    int          n_req;
    int          n_wr;
    logic [31:0] adr;
    logic [31:0] rd;
    logic [31:0] wdat;
    logic [14:0] exp_off;
    e0 = err_cnt;
    for (int i = 0; i < 16; i++) begin
      adr     = {`USB_REGION, 26'($urandom), 2'b00};
      exp_off = adr[16:2];
      n_req   = req_cnt;
      if (i % 2 == 0) begin
        wdat = $urandom;
        n_wr = wr_off_log.size();
        wb_write(adr, wdat, 4'hF, resp, lat);
        check_eq("usb write response", resp, 1);
        check_eq("logged LMMI writes", wr_off_log.size(), n_wr + 1);
        if (wr_off_log.size() > 0) begin
          check_eq("lmmi_offset_o", 32'(wr_off_log[$]), 32'(exp_off));
          check_eq("lmmi_wdata_o", wr_dat_log[$], wdat);
        end
      end else begin
        wb_read(adr, rd, resp, lat);
        check_eq("usb read response", resp, 1);
        check_eq("wb_dat_o usb", rd, {17'd0, exp_off} ^ 32'hA5A5_0000);
      end
      check_eq("lmmi request pulses", req_cnt - n_req, 1);
    end
    test_done("usb_bridge", e0);
  endtask

  task automatic unmapped_space();
    int          e0;
    int          resp;
    int          lat;
    logic [31:0] adr;
    logic [31:0] rd;
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      adr = {4'(3 + $urandom % 13), 26'($urandom), 2'b00};
      wb_write(adr, $urandom, 4'hF, resp, lat);
      check_eq("unmapped write response", resp, 2);   // err, never ack
      check_eq("err latency", lat, 1);
      wb_read(adr, rd, resp, lat);
      check_eq("unmapped read response", resp, 2);
      check_eq("err latency", lat, 1);
    end
    for (int o = 0; o <= `CSR_GAINS; o++) csr_expect(4'(o), csr_model[o]);
    outputs_vs_model();
    test_done("unmapped_space", e0);
  endtask

  // **************************************************
  // LMMI responder, stands in for the USB core
  // **************************************************
  initial begin : lmmi_responder
    logic        rd_pend;
    int          rd_wait;
    logic [31:0] rd_word;
    rd_pend            = 1'b0;
    rd_wait            = 0;
    rd_word            = '0;
    lmmi_ready_i       = 1'b0;
    lmmi_rdata_valid_i = 1'b0;
    lmmi_rdata_i       = '0;
    forever begin
      @(posedge wb_clk_i);
      #1;
      lmmi_ready_i       = ($urandom % 4) != 0;   // Ready about three cycles in four
      lmmi_rdata_valid_i = 1'b0;
      lmmi_rdata_i       = $urandom;              // Junk outside the valid pulse
      if (rd_pend) begin
        rd_wait--;
        if (rd_wait == 0) begin
          lmmi_rdata_valid_i = 1'b1;
          lmmi_rdata_i       = rd_word;
          rd_pend            = 1'b0;
        end
      end
      @(negedge wb_clk_i);
      if (lmmi_request_o) begin
        req_cnt++;
        if (lmmi_wr_rdn_o) begin
          wr_off_log.push_back(lmmi_offset_o);
          wr_dat_log.push_back(lmmi_wdata_o);
        end else begin
          rd_pend = 1'b1;
          rd_wait = 1 + $urandom % 5;   // Data 1 to 5 cycles later
          rd_word = {17'd0, lmmi_offset_o} ^ 32'hA5A5_0000;
        end
      end
    end
  end

  initial begin : main
    void'($urandom(32'h44a1_1c4c));
    reset_i           = 1'b1;
    wb_adr_i          = '0;
    wb_dat_i          = '0;
    wb_sel_i          = '0;
    wb_we_i           = 1'b0;
    wb_cyc_i          = 1'b0;
    wb_stb_i          = 1'b0;
    pll_locked_i      = 1'b0;
    buffer_full_err_i = 1'b0;
    avg_chan_i        = '0;
    csr_model[`CSR_CTRL]       = 32'd0;
    csr_model[`CSR_NUM_COLS]   = `NUM_COLS_DEF;
    csr_model[`CSR_NUM_ROWS]   = `NUM_ROWS_DEF;
    csr_model[`CSR_NUM_FRAMES] = 32'd0;
    csr_model[`CSR_GAINS]      = 32'd0;
    repeat (10) @(posedge wb_clk_i);
    #1;
    reset_i = 1'b0;
    reset_state();
    csr_readback();
    status_regs();
    pixel_stub();
    usb_bridge();
    unmapped_space();
    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Hard stop if something hangs
  initial begin : watchdog
    #1_000_000;
    $display("Simulation ran past its time limit and was stopped");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fpga_top_som.f ====
+incdir+.
fpga_top_som_pkg.sv
wb_addr_decode.sv
wb_csr_bank.sv
wb_lmmi_bridge.sv
fpga_top_som.sv
tb_fpga_top_som.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register-access testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_sim

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f fpga_top_som.f --top-module tb_fpga_top_som -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
fi
exit 1
